//--- include/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Memory word address width
`define CACHE_ADDR_W 16

// Cache word width, equal to the memory port width
`define CACHE_DATA_W 32

// Bytes per word
`define CACHE_NBYTES 4

// Log2 of the words per line
`define CACHE_LINE_W 2

`endif

//--- hdl/cache_pkg.sv
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

   typedef logic [`CACHE_DATA_W-1:0] word_t;
   typedef logic [`CACHE_NBYTES-1:0] strb_t;
   typedef logic [`CACHE_ADDR_W-1:0] addr_t;

   // Word address without the word-in-line bits
   typedef logic [`CACHE_ADDR_W-`CACHE_LINE_W-1:0] line_addr_t;

   typedef logic [`CACHE_LINE_W-1:0] line_idx_t;

   typedef enum logic [1:0] {
      OWN_NONE,
      OWN_READ,
      OWN_WRITE
   } be_owner_e;

endpackage

`default_nettype wire

//--- hdl/cache_read_channel.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_read_channel (
   input  wire                        clk,
   input  wire                        rst_n,

   input  wire                        replace_valid,
   input  wire cache_pkg::line_addr_t replace_addr,
   output logic                       replace,
   output logic                       read_valid,
   output cache_pkg::line_idx_t       read_addr,
   output cache_pkg::word_t           read_rdata,

   output logic                       mem_valid,
   output cache_pkg::addr_t           mem_addr,
   input  wire                        mem_ready,
   input  wire cache_pkg::word_t      mem_rdata
);

   import cache_pkg::*;

   localparam line_idx_t LAST_IDX = line_idx_t'((1 << `CACHE_LINE_W) - 1);

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_FETCH,
      RD_CLOSE
   } rd_state_e;

   rd_state_e  state_q;
   line_addr_t line_q;
   line_idx_t  idx_q;
   logic       accept;
   logic       beat;

   assign accept    = (state_q == RD_IDLE) && replace_valid;
   assign beat      = mem_valid && mem_ready;

   assign replace   = (state_q != RD_IDLE);     // Held through the last returned word
   assign mem_valid = (state_q == RD_FETCH);
   assign mem_addr  = {line_q, idx_q};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= RD_IDLE;
         idx_q   <= '0;
      end else begin
         case (state_q)
            RD_IDLE: begin
               if (accept) begin
                  state_q <= RD_FETCH;
                  idx_q   <= '0;
               end
            end
            RD_FETCH: begin
               if (beat) begin
                  idx_q <= line_idx_t'(idx_q + 1'b1);
                  if (idx_q == LAST_IDX) begin
                     state_q <= RD_CLOSE;            // Last word is out on the read port next
                  end
               end
            end
            default: begin
               state_q <= RD_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         line_q <= replace_addr;
      end
   end

   // Each memory beat shows up on the read port one cycle later
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         read_valid <= 1'b0;
      end else begin
         read_valid <= beat;
      end
   end

   always_ff @(posedge clk) begin
      if (beat) begin
         read_addr  <= idx_q;
         read_rdata <= mem_rdata;
      end
   end

endmodule

`default_nettype wire

//--- hdl/cache_write_channel.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_write_channel (
   input  wire                   clk,
   input  wire                   rst_n,

   input  wire                   write_valid,
   input  wire cache_pkg::addr_t write_addr,
   input  wire cache_pkg::word_t write_wdata,
   input  wire cache_pkg::strb_t write_wstrb,
   output logic                  write_ready,

   output logic                  mem_valid,
   output cache_pkg::addr_t      mem_addr,
   output cache_pkg::word_t      mem_wdata,
   output cache_pkg::strb_t      mem_wstrb,
   input  wire                   mem_ready
);

   import cache_pkg::*;

   logic  full_q;
   logic  accept;
   logic  beat;
   addr_t addr_q;
   word_t wdata_q;
   strb_t wstrb_q;

   assign write_ready = !full_q;                // Only one word may wait for memory
   assign accept      = write_valid && write_ready;

   assign mem_valid   = full_q;
   assign mem_addr    = addr_q;
   assign mem_wdata   = wdata_q;
   assign mem_wstrb   = wstrb_q;
   assign beat        = mem_valid && mem_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         full_q <= 1'b0;
      end else if (accept) begin
         full_q <= 1'b1;
      end else if (beat) begin
         full_q <= 1'b0;                         // Ready again on the cycle after the beat
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q  <= write_addr;
         wdata_q <= write_wdata;
         wstrb_q <= write_wstrb;
      end
   end

endmodule

`default_nettype wire

//--- hdl/cache_be_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_be_arbiter (
   input  wire                   clk,
   input  wire                   rst_n,

   input  wire                   rd_valid,
   input  wire cache_pkg::addr_t rd_addr,
   output logic                  rd_ready,

   input  wire                   wr_valid,
   input  wire cache_pkg::addr_t wr_addr,
   input  wire cache_pkg::word_t wr_wdata,
   input  wire cache_pkg::strb_t wr_wstrb,
   output logic                  wr_ready,

   output logic                  be_valid,
   output cache_pkg::addr_t      be_addr,
   output cache_pkg::word_t      be_wdata,
   output cache_pkg::strb_t      be_wstrb,
   input  wire                   be_ready
);

   import cache_pkg::*;

   localparam line_idx_t LAST_BEAT = line_idx_t'((1 << `CACHE_LINE_W) - 1);

   be_owner_e owner_q;
   be_owner_e grant;
   line_idx_t beat_q;
   logic      beat;
   logic      last_beat;

   // A free port goes to the read channel first
   always_comb begin
      grant = owner_q;
      if (owner_q == OWN_NONE) begin
         if (rd_valid) begin
            grant = OWN_READ;
         end else if (wr_valid) begin
            grant = OWN_WRITE;
         end
      end
   end

   assign be_valid  = ((grant == OWN_READ) && rd_valid) || ((grant == OWN_WRITE) && wr_valid);
   assign be_addr   = (grant == OWN_WRITE) ? wr_addr : rd_addr;
   assign be_wdata  = wr_wdata;
   assign be_wstrb  = (grant == OWN_WRITE) ? wr_wstrb : '0;   // Zero strobes mark a read

   assign rd_ready  = (grant == OWN_READ) && be_ready;
   assign wr_ready  = (grant == OWN_WRITE) && be_ready;

   assign beat      = be_valid && be_ready;
   assign last_beat = (grant == OWN_WRITE) || (beat_q == LAST_BEAT);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         owner_q <= OWN_NONE;
         beat_q  <= '0;
      end else if (beat && last_beat) begin
         owner_q <= OWN_NONE;                   // Free for a new grant next cycle
         beat_q  <= '0;
      end else begin
         owner_q <= grant;
         if (beat) begin
            beat_q <= line_idx_t'(beat_q + 1'b1);
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/cache_back_end.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_back_end (
   input  wire                        clk,
   input  wire                        rst_n,

   input  wire                        write_valid,
   input  wire cache_pkg::addr_t      write_addr,
   input  wire cache_pkg::word_t      write_wdata,
   input  wire cache_pkg::strb_t      write_wstrb,
   output logic                       write_ready,

   input  wire                        replace_valid,
   input  wire cache_pkg::line_addr_t replace_addr,
   output logic                       replace,
   output logic                       read_valid,
   output cache_pkg::line_idx_t       read_addr,
   output cache_pkg::word_t           read_rdata,

   output logic                       be_valid,
   output cache_pkg::addr_t           be_addr,
   output cache_pkg::word_t           be_wdata,
   output cache_pkg::strb_t           be_wstrb,
   input  wire cache_pkg::word_t      be_rdata,
   input  wire                        be_ready
);

   import cache_pkg::*;

   logic  rd_mem_valid;
   logic  rd_mem_ready;
   addr_t rd_mem_addr;

   logic  wr_mem_valid;
   logic  wr_mem_ready;
   addr_t wr_mem_addr;
   word_t wr_mem_wdata;
   strb_t wr_mem_wstrb;

   cache_read_channel read_ch (
      .clk           (clk),
      .rst_n         (rst_n),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace       (replace),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .mem_valid     (rd_mem_valid),
      .mem_addr      (rd_mem_addr),
      .mem_ready     (rd_mem_ready),
      .mem_rdata     (be_rdata)              // Read data needs no arbitration
   );

   cache_write_channel write_ch (
      .clk         (clk),
      .rst_n       (rst_n),
      .write_valid (write_valid),
      .write_addr  (write_addr),
      .write_wdata (write_wdata),
      .write_wstrb (write_wstrb),
      .write_ready (write_ready),
      .mem_valid   (wr_mem_valid),
      .mem_addr    (wr_mem_addr),
      .mem_wdata   (wr_mem_wdata),
      .mem_wstrb   (wr_mem_wstrb),
      .mem_ready   (wr_mem_ready)
   );

   cache_be_arbiter arb (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd_valid (rd_mem_valid),
      .rd_addr  (rd_mem_addr),
      .rd_ready (rd_mem_ready),
      .wr_valid (wr_mem_valid),
      .wr_addr  (wr_mem_addr),
      .wr_wdata (wr_mem_wdata),
      .wr_wstrb (wr_mem_wstrb),
      .wr_ready (wr_mem_ready),
      .be_valid (be_valid),
      .be_addr  (be_addr),
      .be_wdata (be_wdata),
      .be_wstrb (be_wstrb),
      .be_ready (be_ready)
   );

endmodule

`default_nettype wire

//--- verif/clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clk_gen #(
   parameter int HALF_PERIOD = 10
) (
   output logic clk
);

   initial clk = 1'b0;

   always #HALF_PERIOD clk = ~clk;                // 20 ns period with the default

endmodule

`default_nettype wire

//--- verif/be_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module be_mem_model #(
   parameter cache_pkg::word_t FILL_KEY = 32'hA5C3_96E1
) (
   input  wire                   clk,
   input  wire                   rst_n,
   input  wire                   be_valid,
   input  wire cache_pkg::addr_t be_addr,
   input  wire cache_pkg::word_t be_wdata,
   input  wire cache_pkg::strb_t be_wstrb,
   output cache_pkg::word_t      be_rdata,
   output logic                  be_ready
);

   import cache_pkg::*;

   localparam int DEPTH = 1 << `CACHE_ADDR_W;

   word_t      mem [DEPTH];
   logic [1:0] wait_q;
   integer     seed = 94491;

   function automatic logic [1:0] draw_wait();
      logic [31:0] r;
      r = $random(seed);
      return r[1:0];
   endfunction

   initial begin
      for (int a = 0; a < DEPTH; a++) begin
         mem[a] = word_t'(addr_t'(a)) ^ FILL_KEY;   // Every word tells its own address
      end
   end

   assign be_ready = be_valid && (wait_q == 2'd0);
   assign be_rdata = mem[be_addr];

   // Wait states are counted only while a request is up
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wait_q <= 2'd0;
      end else if (be_valid) begin
         if (wait_q == 2'd0) begin
            wait_q <= draw_wait();
         end else begin
            wait_q <= wait_q - 2'd1;
         end
      end
   end

   always @(posedge clk) begin
      if (be_valid && be_ready) begin
         for (int b = 0; b < `CACHE_NBYTES; b++) begin
            if (be_wstrb[b]) begin
               mem[be_addr][8*b +: 8] <= be_wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- verif/tb_cache_back_end.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module tb_cache_back_end;

   import cache_pkg::*;

   localparam word_t FILL_KEY       = 32'hA5C3_96E1;
   localparam int    LINE_WORDS     = 1 << `CACHE_LINE_W;
   localparam int    N_ROWS         = 12;
   localparam int    TIMEOUT_CYCLES = N_ROWS * 40;

   typedef enum int {OP_WRITE, OP_REFILL, OP_BOTH} op_e;

   logic       clk;
   logic       rst_n;
   logic       write_valid;
   addr_t      write_addr;
   word_t      write_wdata;
   strb_t      write_wstrb;
   logic       write_ready;
   logic       replace_valid;
   line_addr_t replace_addr;
   logic       replace;
   logic       read_valid;
   line_idx_t  read_addr;
   word_t      read_rdata;
   logic       be_valid;
   addr_t      be_addr;
   word_t      be_wdata;
   strb_t      be_wstrb;
   word_t      be_rdata;
   logic       be_ready;

   string      row_name  [N_ROWS];
   op_e        row_op    [N_ROWS];
   addr_t      row_waddr [N_ROWS];
   word_t      row_wdata [N_ROWS];
   strb_t      row_wstrb [N_ROWS];
   line_addr_t row_line  [N_ROWS];
   word_t      row_exp   [N_ROWS][LINE_WORDS];
   int         n_rows = 0;

   word_t      shadow [addr_t];                    // Words written so far by the table

   addr_t      beat_addr [$];
   word_t      beat_data [$];
   strb_t      beat_strb [$];
   line_idx_t  rd_idx    [$];
   word_t      rd_data   [$];

   logic       stall_q = 1'b0;
   addr_t      stall_addr;
   int         cycle_cnt = 0;
   int         err_cnt = 0;

   clk_gen clk_src (.clk(clk));

   be_mem_model #(.FILL_KEY(FILL_KEY)) mem (
      .clk      (clk),
      .rst_n    (rst_n),
      .be_valid (be_valid),
      .be_addr  (be_addr),
      .be_wdata (be_wdata),
      .be_wstrb (be_wstrb),
      .be_rdata (be_rdata),
      .be_ready (be_ready)
   );

   cache_back_end UUT (
      .clk           (clk),
      .rst_n         (rst_n),
      .write_valid   (write_valid),
      .write_addr    (write_addr),
      .write_wdata   (write_wdata),
      .write_wstrb   (write_wstrb),
      .write_ready   (write_ready),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace       (replace),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .be_valid      (be_valid),
      .be_addr       (be_addr),
      .be_wdata      (be_wdata),
      .be_wstrb      (be_wstrb),
      .be_rdata      (be_rdata),
      .be_ready      (be_ready)
   );

   task automatic check_value(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         err_cnt++;
         $display("mismatch %s: expected %0h, actual %0h", test, expected, actual);
         $display("Done: errors found");
         $fatal(1, "stopping at the first error");
      end
   endtask

   function automatic word_t fill_word(input addr_t a);
      return word_t'(a) ^ FILL_KEY;
   endfunction

   function automatic word_t shadow_word(input addr_t a);
      return shadow.exists(a) ? shadow[a] : fill_word(a);
   endfunction

   function automatic word_t merge_word(input word_t old_w, input word_t new_w, input strb_t strb);
      word_t w;
      w = old_w;
      for (int b = 0; b < `CACHE_NBYTES; b++) begin
         if (strb[b]) begin
            w[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return w;
   endfunction

   // Read wins over a write issued in the same cycle, so the line is taken before the write
   task automatic add_row(input string name, input op_e op, input addr_t waddr,
                          input word_t wdata, input strb_t wstrb, input line_addr_t line);
      row_name[n_rows]  = name;
      row_op[n_rows]    = op;
      row_waddr[n_rows] = waddr;
      row_wdata[n_rows] = wdata;
      row_wstrb[n_rows] = wstrb;
      row_line[n_rows]  = line;
      for (int k = 0; k < LINE_WORDS; k++) begin
         row_exp[n_rows][k] = shadow_word(addr_t'({line, line_idx_t'(k)}));
      end
      if (op != OP_REFILL) begin
         shadow[waddr] = merge_word(shadow_word(waddr), wdata, wstrb);
      end
      n_rows++;
   endtask

   task automatic build_table();
      add_row("refill_plain",    OP_REFILL, 16'h0000, 32'h0,         4'h0,    14'h0010);
      add_row("write_full",      OP_WRITE,  16'h0123, 32'hDEAD_BEEF, 4'hF,    14'h0000);
      add_row("write_partial",   OP_WRITE,  16'h0041, 32'h1122_3344, 4'b0101, 14'h0000);
      add_row("refill_merged",   OP_REFILL, 16'h0000, 32'h0,         4'h0,    14'h0010);
      add_row("write_hi_bytes",  OP_WRITE,  16'h0042, 32'hCAFE_F00D, 4'b1100, 14'h0000);
      add_row("both_apart",      OP_BOTH,   16'h0200, 32'h0BAD_F00D, 4'hF,    14'h0123);
      add_row("both_same_line",  OP_BOTH,   16'h0043, 32'h5555_AAAA, 4'b0011, 14'h0010);
      add_row("refill_after",    OP_REFILL, 16'h0000, 32'h0,         4'h0,    14'h0010);
      add_row("write_top",       OP_WRITE,  16'hFFFF, 32'h0F0F_0F0F, 4'b1000, 14'h0000);
      add_row("refill_top",      OP_REFILL, 16'h0000, 32'h0,         4'h0,    14'h3FFF);
      add_row("both_one_byte",   OP_BOTH,   16'h0081, 32'h0000_7700, 4'b0010, 14'h0080);
      add_row("refill_one_byte", OP_REFILL, 16'h0000, 32'h0,         4'h0,    14'h0020);
   endtask

   task automatic run_row(input int i);
      logic w_pend;
      logic r_pend;
      logic w_acc;
      logic r_acc;
      int   n_rd;
      int   n_wr;
      w_pend = (row_op[i] != OP_REFILL);
      r_pend = (row_op[i] != OP_WRITE);
      n_rd   = r_pend ? LINE_WORDS : 0;
      n_wr   = w_pend ? 1 : 0;
      beat_addr.delete();
      beat_data.delete();
      beat_strb.delete();
      rd_idx.delete();
      rd_data.delete();
      @(posedge clk);
      #1;
      write_valid   = w_pend;
      write_addr    = row_waddr[i];
      write_wdata   = row_wdata[i];
      write_wstrb   = row_wstrb[i];
      replace_valid = r_pend;
      replace_addr  = row_line[i];
      while (w_pend || r_pend) begin
         w_acc = w_pend && write_ready;
         r_acc = r_pend && !replace;
         @(posedge clk);
         #1;
         if (w_acc) begin
            w_pend      = 1'b0;
            write_valid = 1'b0;
         end
         if (r_acc) begin
            r_pend        = 1'b0;
            replace_valid = 1'b0;
         end
      end
      while (!write_ready || replace) begin
         @(posedge clk);
         #1;
      end
      check_value({row_name[i], " beat count"}, 32'(n_rd + n_wr), 32'(beat_addr.size()));
      for (int p = 0; p < n_rd + n_wr; p++) begin
         if (p < n_rd) begin
            check_value({row_name[i], " read beat strobes"}, 32'(0), 32'(beat_strb[p]));
            check_value({row_name[i], " read beat addr"},
                        32'(addr_t'({row_line[i], line_idx_t'(p)})), 32'(beat_addr[p]));
         end else begin
            check_value({row_name[i], " write beat strobes"}, 32'(row_wstrb[i]),
                        32'(beat_strb[p]));
            check_value({row_name[i], " write beat addr"}, 32'(row_waddr[i]),
                        32'(beat_addr[p]));
            check_value({row_name[i], " write beat data"}, row_wdata[i], beat_data[p]);
         end
      end
      check_value({row_name[i], " read pulses"}, 32'(n_rd), 32'(rd_idx.size()));
      for (int k = 0; k < n_rd; k++) begin
         check_value({row_name[i], " read index"}, 32'(k), 32'(rd_idx[k]));
         check_value({row_name[i], " read data"}, row_exp[i][k], rd_data[k]);
      end
      check_value({row_name[i], " port idle"}, 32'(0), 32'(be_valid));
      check_value({row_name[i], " read idle"}, 32'(0), 32'(read_valid));
   endtask

   // Samples at the edge see the values held during the cycle before it
   always @(posedge clk) begin
      if (rst_n && stall_q) begin
         check_value("request_hold valid", 32'(1), 32'(be_valid));
         check_value("request_hold addr", 32'(stall_addr), 32'(be_addr));
      end
      stall_q    <= be_valid && !be_ready;
      stall_addr <= be_addr;
      if (be_valid && be_ready) begin
         beat_addr.push_back(be_addr);
         beat_data.push_back(be_wdata);
         beat_strb.push_back(be_wstrb);
      end
      if (read_valid) begin
         rd_idx.push_back(read_addr);
         rd_data.push_back(read_rdata);
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Done: errors found");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   initial begin
      rst_n         = 1'b0;
      write_valid   = 1'b0;
      write_addr    = '0;
      write_wdata   = '0;
      write_wstrb   = '0;
      replace_valid = 1'b0;
      replace_addr  = '0;
      build_table();
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_value("reset write_ready", 32'(1), 32'(write_ready));
      check_value("reset replace", 32'(0), 32'(replace));
      check_value("reset read_valid", 32'(0), 32'(read_valid));
      check_value("reset be_valid", 32'(0), 32'(be_valid));
      for (int i = 0; i < n_rows; i++) begin
         run_row(i);
      end
      if (err_cnt == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
hdl/cache_pkg.sv
hdl/cache_read_channel.sv
hdl/cache_write_channel.sv
hdl/cache_be_arbiter.sv
hdl/cache_back_end.sv
verif/clk_gen.sv
verif/be_mem_model.sv
verif/tb_cache_back_end.sv

//--- Makefile
# Verilator build and run for the cache back end testbench

TOP := tb_cache_back_end

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f build.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Done: no errors$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
